//--- dv/fetch_unit_stim.txt
# All fields hex. M line_addr slot0 slot1 slot2 slot3 / U pc taken target / B boot_pc
# E pc instr taken target / R rows_checked redirect_pc
M 100 01000093 01100093 01200093 01300093
M 110 02000093 02100093 02200093 02300093
M 120 03000093 0e208e63 03200093 03300093
M 200 04000093 0400006f 04200093 04300093
M 210 05000093 05100093 05200093 05300093
M 400 06000093 06100093 06200093 06300093
M 410 07000093 07100093 07200093 07300093
U 124 1 200
U 124 1 200
U 200 1 300
U 204 1 340
U 204 0 0
B 108
E 108 01200093 0 0
E 10c 01300093 0 0
E 110 02000093 0 0
E 114 02100093 0 0
E 118 02200093 0 0
E 11c 02300093 0 0
E 120 03000093 0 0
E 124 0e208e63 1 200
E 200 04000093 0 0
E 204 0400006f 0 0
E 208 04200093 0 0
E 20c 04300093 0 0
E 210 05000093 0 0
R d 404
E 404 06100093 0 0
E 408 06200093 0 0
E 40c 06300093 0 0
E 410 07000093 0 0
E 414 07100093 0 0

//--- fetch_unit.f
+incdir+common
common/fetch_pkg.sv
common/pred_if.sv
source/pc_ctrl.sv
bpu/bht.sv
bpu/btb.sv
source/instr_admin.sv
source/instr_buffer.sv
source/fetch_unit.sv
dv/fetch_unit_assertions.sv
dv/fetch_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the fetch unit testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
    --top-module fetch_unit_tb -f fetch_unit.f -o fetch_unit_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/fetch_unit_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qF "** PASS **"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

//--- dv/fetch_unit_tb.sv
module fetch_unit_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import fetch_pkg::*;

    logic        clk;
    logic        arst_n;
    logic        fetch_en;
    logic        redirect_valid;
    pc_t         redirect_pc;
    logic        upd_valid;
    pc_t         upd_pc;
    logic        upd_taken;
    target_t     upd_target;
    logic        imem_req;
    pc_t         imem_addr;
    fetch_line_t imem_line;
    logic        out_ready;
    logic        out_valid;
    instr_t      out_instr;
    pc_t         out_pc;
    logic        out_pred_taken;
    target_t     out_pred_target;

    fetch_line_t imem [pc_t];   // Keyed by 16-byte line address
    pc_t         u_pc [$];
    logic        u_taken [$];
    target_t     u_target [$];
    pc_t         boot_pc;
    pc_t         e_pc [$];
    instr_t      e_instr [$];
    logic        e_taken [$];
    target_t     e_target [$];
    int          r_after [$];   // Redirect once this many E rows are checked
    pc_t         r_pc [$];
    int          checked;
    logic [31:0] rng;
    bit          stim_loaded = 1'b0;

    fetch_unit uut (.*);

    bind fetch_unit fetch_unit_assertions u_fetch_assertions (
        .clk         (clk),
        .arst_n      (arst_n),
        .imem_req    (imem_req),
        .ib_space_ok (ib_space_ok),
        .out_valid   (out_valid),
        .out_pc      (out_pc)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            abort_run($sformatf("Fail %s (row %0d): got 0x%h, expected 0x%h",
                                name, checked, got, expected));
        end
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Unloaded lines mix every address bit into each slot
    function automatic fetch_line_t fill_line(input pc_t addr);
        logic [31:0] mix;
        mix = addr[63:32] ^ addr[31:0];
        return {4{mix}} ^ {32'h0000_000c, 32'h0000_0008, 32'h0000_0004, 32'h0000_0000};
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic read_stim();
        int               fd;
        int               code;
        logic [7:0]       tag;
        logic [63:0]      a;
        logic [63:0]      b;
        logic [63:0]      c;
        logic [63:0]      d;
        logic [63:0]      e;
        logic [8*160-1:0] rest;
        fd = $fopen("dv/fetch_unit_stim.txt", "r");
        if (fd == 0) begin
            abort_run("Cannot open the stimulus file dv/fetch_unit_stim.txt");
        end
        code = $fscanf(fd, " %c", tag);
        while (code == 1) begin
            case (tag)
                "#": code = $fgets(rest, fd);     // Column notes
                "M": begin
                    code = $fscanf(fd, "%h %h %h %h %h", a, b, c, d, e);
                    imem[a] = {e[31:0], d[31:0], c[31:0], b[31:0]};
                end
                "U": begin
                    code = $fscanf(fd, "%h %h %h", a, b, c);
                    u_pc.push_back(a);
                    u_taken.push_back(b[0]);
                    u_target.push_back(c[31:0]);
                end
                "B": code = $fscanf(fd, "%h", boot_pc);
                "E": begin
                    code = $fscanf(fd, "%h %h %h %h", a, b, c, d);
                    e_pc.push_back(a);
                    e_instr.push_back(b[31:0]);
                    e_taken.push_back(c[0]);
                    e_target.push_back(d[31:0]);
                end
                "R": begin
                    code = $fscanf(fd, "%h %h", a, b);
                    r_after.push_back(int'(a));
                    r_pc.push_back(b);
                end
                default: abort_run("Unknown row type in the stimulus file");
            endcase
            code = $fscanf(fd, " %c", tag);
        end
        $fclose(fd);
    endtask

    task automatic apply_training();
        for (int i = 0; i < u_pc.size(); i++) begin
            upd_valid  = 1'b1;
            upd_pc     = u_pc[i];
            upd_taken  = u_taken[i];
            upd_target = u_target[i];
            next_cycle();
        end
        upd_valid = 1'b0;
    endtask

    task automatic boot_fetch();
        redirect_valid = 1'b1;
        redirect_pc    = boot_pc;
        next_cycle();
        redirect_valid = 1'b0;
        fetch_en       = 1'b1;
    endtask

    task automatic run_stream();
        int r_idx;
        r_idx = 0;
        while (checked < e_pc.size()) begin
            if (r_idx < r_after.size() && checked == r_after[r_idx]) begin
                redirect_valid = 1'b1;
                redirect_pc    = r_pc[r_idx];
                out_ready      = 1'b0;  // No pop while the buffer flushes
                r_idx++;
            end else begin
                redirect_valid = 1'b0;
                rng            = lcg_next(rng);
                out_ready      = (rng[31:30] != 2'b00);
            end
            @(negedge clk);
            if (out_valid && out_ready) begin
                check_value("out_pc", out_pc, e_pc[checked]);
                check_value("out_instr", 64'(out_instr), 64'(e_instr[checked]));
                check_value("out_pred_taken", 64'(out_pred_taken), 64'(e_taken[checked]));
                check_value("out_pred_target", 64'(out_pred_target), 64'(e_target[checked]));
                checked++;
            end
            next_cycle();
        end
        redirect_valid = 1'b0;
        out_ready      = 1'b0;
    endtask

    // Memory model answers one cycle after each request
    initial begin
        pc_t  req_addr;
        logic req_seen;
        imem_line = '0;
        forever begin
            @(negedge clk);
            req_seen = imem_req;
            req_addr = imem_addr;
            @(posedge clk);
            #2;
            if (req_seen) begin
                imem_line = imem.exists(req_addr) ? imem[req_addr] : fill_line(req_addr);
            end else begin
                imem_line = '0;
            end
        end
    end

    initial begin
        int limit;
        wait (stim_loaded);
        limit = 40 * e_pc.size() + 2 * u_pc.size() + 24;   // Reset and training on top
        repeat (limit) @(posedge clk);
        abort_run("Timeout: not every expected instruction was issued in time");
    end

    initial begin
        int assert_errs;
        arst_n         = 1'b0;
        fetch_en       = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        upd_valid      = 1'b0;
        upd_pc         = '0;
        upd_taken      = 1'b0;
        upd_target     = '0;
        out_ready      = 1'b0;
        rng            = 32'h2ba0;
        checked        = 0;
        read_stim();
        stim_loaded = 1'b1;
        repeat (8) @(posedge clk);
        #2;
        arst_n = 1'b1;
        apply_training();
        boot_fetch();
        run_stream();
        assert_errs = uut.u_fetch_assertions.req_pair_errs
                    + uut.u_fetch_assertions.req_space_errs
                    + uut.u_fetch_assertions.pc_align_errs;
        if (e_pc.size() > 0 && checked == e_pc.size() && assert_errs == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            abort_run("Assertion failures or no expected instructions at the end of the run");
        end
    end

endmodule

//--- dv/fetch_unit_assertions.sv
module fetch_unit_assertions (
    input logic           clk,
    input logic           arst_n,
    input logic           imem_req,
    input logic           ib_space_ok,
    input logic           out_valid,
    input fetch_pkg::pc_t out_pc
);
    timeunit 1ns;
    timeprecision 100ps;

    int req_pair_errs  = 0;
    int req_space_errs = 0;
    int pc_align_errs  = 0;

    // Only one line request may be in flight
    property req_not_back_to_back;
        @(posedge clk) disable iff (!arst_n) imem_req |=> !imem_req;
    endproperty

    property req_with_space;
        @(posedge clk) disable iff (!arst_n) imem_req |-> ib_space_ok;
    endproperty

    property out_pc_aligned;
        @(posedge clk) disable iff (!arst_n) out_valid |-> (out_pc[1:0] == 2'b00);
    endproperty

    a_req_pair: assert property (req_not_back_to_back) else begin
        req_pair_errs++;
        $error("imem_req was high in two consecutive cycles");
    end

    a_req_space: assert property (req_with_space) else begin
        req_space_errs++;
        $error("imem_req issued while ib_space_ok was low");
    end

    a_pc_align: assert property (out_pc_aligned) else begin
        pc_align_errs++;
        $error("out_pc is not 4-byte aligned");
    end

endmodule

//--- source/fetch_unit.sv
module fetch_unit (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   fetch_en,
    input  logic                   redirect_valid,
    input  fetch_pkg::pc_t         redirect_pc,
    input  logic                   upd_valid,
    input  fetch_pkg::pc_t         upd_pc,
    input  logic                   upd_taken,
    input  fetch_pkg::target_t     upd_target,
    output logic                   imem_req,
    output fetch_pkg::pc_t         imem_addr,
    input  fetch_pkg::fetch_line_t imem_line,
    input  logic                   out_ready,
    output logic                   out_valid,
    output fetch_pkg::instr_t      out_instr,
    output fetch_pkg::pc_t         out_pc,
    output logic                   out_pred_taken,
    output fetch_pkg::target_t     out_pred_target
);
    import fetch_pkg::*;

    pc_t         fetch_pc;
    logic        rd_en;
    logic        pc_operation_done;
    logic        ib_space_ok;
    fetch_line_t admin2ib_instr;
    slot_mask_t  admin2ib_instr_valid;
    slot_mask_t  admin2ib_predicttaken;
    btb_line_t   admin2ib_predicttarget;
    logic        admin2pcctrl_predicttaken;
    target_t     admin2pcctrl_predicttarget;

    pred_if pred ();

    assign rd_en     = imem_req;                    // Predictors read alongside the line
    assign imem_addr = {fetch_pc[63:4], 4'b0000};

    pc_ctrl u_pc_ctrl (
        .clk                        (clk),
        .arst_n                     (arst_n),
        .fetch_en                   (fetch_en),
        .redirect_valid             (redirect_valid),
        .redirect_pc                (redirect_pc),
        .ib_space_ok                (ib_space_ok),
        .admin2pcctrl_predicttaken  (admin2pcctrl_predicttaken),
        .admin2pcctrl_predicttarget (admin2pcctrl_predicttarget),
        .imem_req                   (imem_req),
        .fetch_pc                   (fetch_pc),
        .pc_operation_done          (pc_operation_done)
    );

    bht u_bht (
        .clk       (clk),
        .arst_n    (arst_n),
        .rd_en     (rd_en),
        .fetch_pc  (fetch_pc),
        .upd_valid (upd_valid),
        .upd_pc    (upd_pc),
        .upd_taken (upd_taken),
        .pred      (pred.bht)
    );

    btb u_btb (
        .clk        (clk),
        .arst_n     (arst_n),
        .rd_en      (rd_en),
        .fetch_pc   (fetch_pc),
        .upd_valid  (upd_valid),
        .upd_pc     (upd_pc),
        .upd_taken  (upd_taken),
        .upd_target (upd_target),
        .pred       (pred.btb)
    );

    instr_admin u_instr_admin (
        .pc_operation_done          (pc_operation_done),
        .fetch_instr                (imem_line),
        .pc                         (fetch_pc),
        .pred                       (pred.admin),
        .admin2ib_instr             (admin2ib_instr),
        .admin2ib_instr_valid       (admin2ib_instr_valid),
        .admin2ib_predicttaken      (admin2ib_predicttaken),
        .admin2ib_predicttarget     (admin2ib_predicttarget),
        .admin2pcctrl_predicttaken  (admin2pcctrl_predicttaken),
        .admin2pcctrl_predicttarget (admin2pcctrl_predicttarget)
    );

    instr_buffer u_instr_buffer (
        .clk                    (clk),
        .arst_n                 (arst_n),
        .flush                  (redirect_valid),   // Queue is stale after a redirect
        .pc_operation_done      (pc_operation_done),
        .line_pc                (fetch_pc),
        .admin2ib_instr         (admin2ib_instr),
        .admin2ib_instr_valid   (admin2ib_instr_valid),
        .admin2ib_predicttaken  (admin2ib_predicttaken),
        .admin2ib_predicttarget (admin2ib_predicttarget),
        .ib_space_ok            (ib_space_ok),
        .out_ready              (out_ready),
        .out_valid              (out_valid),
        .out_instr              (out_instr),
        .out_pc                 (out_pc),
        .out_pred_taken         (out_pred_taken),
        .out_pred_target        (out_pred_target)
    );

endmodule

//--- source/instr_buffer.sv
`include "fetch_defines.svh"

module instr_buffer (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   flush,
    input  logic                   pc_operation_done,
    input  fetch_pkg::pc_t         line_pc,
    input  fetch_pkg::fetch_line_t admin2ib_instr,
    input  fetch_pkg::slot_mask_t  admin2ib_instr_valid,
    input  fetch_pkg::slot_mask_t  admin2ib_predicttaken,
    input  fetch_pkg::btb_line_t   admin2ib_predicttarget,
    output logic                   ib_space_ok,
    input  logic                   out_ready,
    output logic                   out_valid,
    output fetch_pkg::instr_t      out_instr,
    output fetch_pkg::pc_t         out_pc,
    output logic                   out_pred_taken,
    output fetch_pkg::target_t     out_pred_target
);
    import fetch_pkg::*;

    localparam int PTR_W = $clog2(`IB_DEPTH);

    instr_t           instr_mem  [`IB_DEPTH];
    pc_t              pc_mem     [`IB_DEPTH];
    logic             taken_mem  [`IB_DEPTH];
    target_t          target_mem [`IB_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic [PTR_W:0]   n_push;
    logic             pop;
    pc_t              base_pc;

    assign base_pc = {line_pc[63:2], 2'b00};    // PC of aligned slot 0
    assign pop     = out_valid && out_ready;

    // Valid slots are packed from slot 0 upward
    always_comb begin
        n_push = '0;
        if (pc_operation_done) begin
            for (int i = 0; i < `FETCH_SLOTS; i++) begin
                n_push = n_push + (PTR_W+1)'(admin2ib_instr_valid[i]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pc_operation_done) begin
            for (int i = 0; i < `FETCH_SLOTS; i++) begin
                if (admin2ib_instr_valid[i]) begin
                    instr_mem[wr_ptr + PTR_W'(i)]  <= admin2ib_instr[32*i +: 32];
                    pc_mem[wr_ptr + PTR_W'(i)]     <= base_pc + pc_t'(4 * i);
                    taken_mem[wr_ptr + PTR_W'(i)]  <= admin2ib_predicttaken[i];
                    target_mem[wr_ptr + PTR_W'(i)] <= admin2ib_predicttarget[32*i +: 32];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;   // Drop everything still queued
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + n_push[PTR_W-1:0];
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + n_push - (PTR_W+1)'(pop);
        end
    end

    assign ib_space_ok     = (count <= (PTR_W+1)'(`IB_DEPTH - `FETCH_SLOTS));  // Room for a line
    assign out_valid       = (count != '0);
    assign out_instr       = instr_mem[rd_ptr];
    assign out_pc          = pc_mem[rd_ptr];
    assign out_pred_taken  = taken_mem[rd_ptr];
    assign out_pred_target = target_mem[rd_ptr];

endmodule

//--- source/instr_admin.sv
`include "fetch_defines.svh"

module instr_admin (
    input  logic                   pc_operation_done,
    input  fetch_pkg::fetch_line_t fetch_instr,
    input  fetch_pkg::pc_t         pc,
    pred_if.admin                  pred,
    output fetch_pkg::fetch_line_t admin2ib_instr,
    output fetch_pkg::slot_mask_t  admin2ib_instr_valid,
    output fetch_pkg::slot_mask_t  admin2ib_predicttaken,
    output fetch_pkg::btb_line_t   admin2ib_predicttarget,
    output logic                   admin2pcctrl_predicttaken,
    output fetch_pkg::target_t     admin2pcctrl_predicttarget
);
    import fetch_pkg::*;

    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    fetch_line_t aligned_instr;
    slot_mask_t  aligned_valid;
    slot_mask_t  is_jump;
    slot_mask_t  bpu_taken;
    slot_mask_t  jump_taken;
    slot_mask_t  first_taken;
    slot_mask_t  keep;

    function automatic logic is_ctrl_flow(instr_t instr);
        logic [6:0] opcode;
        opcode = instr[6:0];
        return (opcode == OP_JAL) || (opcode == OP_JALR) || (opcode == OP_BRANCH);
    endfunction

    // Lowest set bit as a one-hot mask
    function automatic slot_mask_t first_one(slot_mask_t vec);
        return vec & (~vec + slot_mask_t'(1));
    endfunction

    // Drop the slots in front of the PC
    always_comb begin
        aligned_instr = '0;
        aligned_valid = '0;
        if (pc_operation_done) begin
            aligned_instr = fetch_instr >> (32 * pc[3:2]);
            aligned_valid = {`FETCH_SLOTS{1'b1}} >> pc[3:2];
        end
    end

    // Counters are read by the unshifted slot number
    always_comb begin
        for (int i = 0; i < `FETCH_SLOTS; i++) begin
            is_jump[i]   = is_ctrl_flow(aligned_instr[32*i +: 32]);
            bpu_taken[i] = pred.bht_read_data[2*i+1] & pred.bht_valid & pred.btb_valid;
        end
    end

    assign jump_taken  = aligned_valid & is_jump & bpu_taken;
    assign first_taken = first_one(jump_taken);
    assign keep        = aligned_valid & ((first_taken - slot_mask_t'(1)) | first_taken);

    always_comb begin
        admin2pcctrl_predicttarget = '0;
        for (int i = 0; i < `FETCH_SLOTS; i++) begin
            admin2ib_instr[32*i +: 32]         = keep[i] ? aligned_instr[32*i +: 32] : '0;
            admin2ib_predicttarget[32*i +: 32] = first_taken[i] ?
                                                 pred.btb_targets[32*i +: 32] : '0;
            if (first_taken[i]) begin
                admin2pcctrl_predicttarget = pred.btb_targets[32*i +: 32];
            end
        end
    end

    assign admin2ib_instr_valid      = keep;        // Line ends at the taken jump
    assign admin2ib_predicttaken     = first_taken;
    assign admin2pcctrl_predicttaken = |first_taken;

endmodule

//--- bpu/btb.sv
`include "fetch_defines.svh"

module btb (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               rd_en,
    input  fetch_pkg::pc_t     fetch_pc,
    input  logic               upd_valid,
    input  fetch_pkg::pc_t     upd_pc,
    input  logic               upd_taken,
    input  fetch_pkg::target_t upd_target,
    pred_if.btb                pred
);
    import fetch_pkg::*;

    localparam int ENTRIES  = 1 << `BTB_INDEX_BITS;
    localparam int TAG_BITS = 64 - 4 - `BTB_INDEX_BITS;

    logic [TAG_BITS-1:0]        tags    [ENTRIES];
    btb_line_t                  targets [ENTRIES];
    logic [ENTRIES-1:0]         valid_q;
    logic [`BTB_INDEX_BITS-1:0] rd_idx;
    logic [`BTB_INDEX_BITS-1:0] upd_idx;
    logic [TAG_BITS-1:0]        rd_tag;
    logic [TAG_BITS-1:0]        upd_tag;
    logic                       upd_write;
    logic                       rd_hit;

    assign rd_idx    = fetch_pc[4 +: `BTB_INDEX_BITS];
    assign rd_tag    = fetch_pc[63 -: TAG_BITS];
    assign upd_idx   = upd_pc[4 +: `BTB_INDEX_BITS];
    assign upd_tag   = upd_pc[63 -: TAG_BITS];
    assign upd_write = upd_valid && upd_taken;     // Only taken updates allocate
    assign rd_hit    = valid_q[rd_idx] && (tags[rd_idx] == rd_tag);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else if (upd_write) begin
            valid_q[upd_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (upd_write) begin
            tags[upd_idx]                        <= upd_tag;
            targets[upd_idx][32*upd_pc[3:2] +: 32] <= upd_target;   // Slot of the branch
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pred.btb_valid <= 1'b0;
        end else begin
            pred.btb_valid <= rd_en && rd_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            pred.btb_targets <= targets[rd_idx];
        end
    end

endmodule

//--- bpu/bht.sv
`include "fetch_defines.svh"

module bht (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           rd_en,
    input  fetch_pkg::pc_t fetch_pc,
    input  logic           upd_valid,
    input  fetch_pkg::pc_t upd_pc,
    input  logic           upd_taken,
    pred_if.bht            pred
);
    import fetch_pkg::*;

    localparam int ENTRIES = 1 << `BHT_INDEX_BITS;

    bht_line_t                  counters [ENTRIES];
    logic [`BHT_INDEX_BITS-1:0] rd_idx;
    logic [`BHT_INDEX_BITS-1:0] upd_idx;
    logic [1:0]                 upd_slot;
    logic [1:0]                 cnt_old;
    logic [1:0]                 cnt_new;

    assign rd_idx   = fetch_pc[4 +: `BHT_INDEX_BITS];  // Bits above the line offset
    assign upd_idx  = upd_pc[4 +: `BHT_INDEX_BITS];
    assign upd_slot = upd_pc[3:2];
    assign cnt_old  = counters[upd_idx][2*upd_slot +: 2];

    // Saturating up/down count
    always_comb begin
        cnt_new = cnt_old;
        if (upd_taken && cnt_old != 2'b11) begin
            cnt_new = cnt_old + 2'b01;
        end else if (!upd_taken && cnt_old != 2'b00) begin
            cnt_new = cnt_old - 2'b01;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < ENTRIES; i++) begin
                counters[i] <= {`FETCH_SLOTS{2'b01}};   // Weakly not-taken
            end
        end else if (upd_valid) begin
            counters[upd_idx][2*upd_slot +: 2] <= cnt_new;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pred.bht_valid <= 1'b0;
        end else begin
            pred.bht_valid <= rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            pred.bht_read_data <= counters[rd_idx];
        end
    end

endmodule

//--- source/pc_ctrl.sv
module pc_ctrl (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               fetch_en,
    input  logic               redirect_valid,
    input  fetch_pkg::pc_t     redirect_pc,
    input  logic               ib_space_ok,
    input  logic               admin2pcctrl_predicttaken,
    input  fetch_pkg::target_t admin2pcctrl_predicttarget,
    output logic               imem_req,
    output fetch_pkg::pc_t     fetch_pc,
    output logic               pc_operation_done
);
    import fetch_pkg::*;

    fetch_state_t state;
    fetch_state_t state_next;
    pc_t          pc_next;
    pc_t          line_end;
    logic         kill_q;       // Line in flight overtaken by a redirect

    assign line_end = {fetch_pc[63:4], 4'b0000} + 64'd16;   // Next 16-byte boundary

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (fetch_en && ib_space_ok) begin
                    state_next = REQ;
                end
            end
            REQ: begin
                state_next = WAIT;
            end
            WAIT: begin
                state_next = IDLE;  // Buffer space is checked again in IDLE
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    // A redirect always wins over the sequential or predicted PC
    always_comb begin
        pc_next = fetch_pc;
        if (redirect_valid) begin
            pc_next = redirect_pc;
        end else if (state == WAIT && !kill_q) begin
            if (admin2pcctrl_predicttaken) begin
                pc_next = {32'd0, admin2pcctrl_predicttarget};  // Zero-extended target
            end else begin
                pc_next = line_end;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= IDLE;
            fetch_pc <= '0;
            kill_q   <= 1'b0;
        end else begin
            state    <= state_next;
            fetch_pc <= pc_next;
            if (state == REQ && redirect_valid) begin
                kill_q <= 1'b1;     // PC no longer matches the returning line
            end else if (state == WAIT) begin
                kill_q <= 1'b0;
            end
        end
    end

    assign imem_req = (state == REQ);

    // The returning line is dropped when a redirect has overtaken it
    assign pc_operation_done = (state == WAIT) && !redirect_valid && !kill_q;

endmodule

//--- common/pred_if.sv
interface pred_if;
    import fetch_pkg::*;

    bht_line_t bht_read_data;   // Four counters of the fetched line
    logic      bht_valid;
    btb_line_t btb_targets;     // Four slot targets
    logic      btb_valid;       // Tag hit on the last read

    modport bht (output bht_read_data, output bht_valid);

    modport btb (output btb_targets, output btb_valid);

    modport admin (
        input bht_read_data,
        input bht_valid,
        input btb_targets,
        input btb_valid
    );

endinterface

//--- common/fetch_pkg.sv
`include "fetch_defines.svh"

package fetch_pkg;

    typedef logic [63:0]                pc_t;
    typedef logic [31:0]                instr_t;
    typedef logic [32*`FETCH_SLOTS-1:0] fetch_line_t;   // Slot 0 in the low bits
    typedef logic [`FETCH_SLOTS-1:0]    slot_mask_t;

    // Prediction data for one line
    typedef logic [2*`FETCH_SLOTS-1:0]  bht_line_t;     // One 2-bit counter per slot
    typedef logic [31:0]                target_t;
    typedef logic [32*`FETCH_SLOTS-1:0] btb_line_t;     // One target per slot

    // Fetch controller states
    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT
    } fetch_state_t;

endpackage

//--- common/fetch_defines.svh
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// Fetch line geometry
`define FETCH_SLOTS     4   // Instructions per 16-byte line

// Predictor sizes
`define BHT_INDEX_BITS  6   // 64 BHT entries
`define BTB_INDEX_BITS  4   // 16 BTB entries

// Instruction buffer
`define IB_DEPTH        8   // Must stay a power of two

`endif
